//--- project.f
verilog/matrix_adder_pkg.sv
verilog/matrix_order.sv
verilog/row_adder.sv
verilog/add_controller.sv
verilog/result_store.sv
verilog/matrix_adder.sv
verification/tb_matrix_adder.sv

//--- run.sh
#!/bin/sh
# build and run the matrix adder testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_matrix_adder -f project.f

# the simulator exits non-zero on a failed check, the log decides the result
./obj_dir/Vtb_matrix_adder > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

//--- verification/tb_matrix_adder.sv
`default_nettype none

module tb_matrix_adder;
    import matrix_adder_pkg::*;

    localparam int clk_period   = 10;
    localparam int reset_cycles = 5;
    localparam int num_trials   = 40;
    localparam int idle_cycles  = 3;
    localparam int add_cycles   = 5;
    localparam int done_limit   = 12;

    logic        clk;
    logic        reset_n;
    logic        start;
    mat_dims_t   dims_a;
    mat_dims_t   dims_b;
    grid_t       data_a;
    grid_t       data_b;
    logic        busy;
    logic        done;
    logic        dims_ok;
    mat_dims_t   dims_out;
    grid_t       result;
    logic [31:0] lfsr_state;

    matrix_adder DUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .start    (start),
        .dims_a   (dims_a),
        .dims_b   (dims_b),
        .data_a   (data_a),
        .data_b   (data_b),
        .busy     (busy),
        .done     (done),
        .dims_ok  (dims_ok),
        .dims_out (dims_out),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic mat_dims_t random_dims();
        mat_dims_t d;
        d.rows = dim_width'(take_bits(3) % 5 + 1);
        d.cols = dim_width'(take_bits(3) % 5 + 1);
        return d;
    endfunction

    // near_max keeps every element in 504..511
    function automatic grid_t random_grid(input bit near_max);
        grid_t g;
        for (int i = 0; i < grid_size; i++) begin
            if (near_max) begin
                g[i] = elem_t'(511 - take_bits(3));
            end else begin
                g[i] = elem_t'(take_bits(elem_width));
            end
        end
        return g;
    endfunction

    // dense element k lands at row k / cols, column k % cols
    function automatic grid_t model_order(input mat_dims_t d, input grid_t dense);
        grid_t g;
        int    cols;
        int    used;
        g    = '0;
        cols = int'(d.cols);
        used = int'(d.rows) * cols;
        for (int k = 0; k < used; k++) begin
            g[(k / cols) * grid_dim + (k % cols)] = dense[k];
        end
        return g;
    endfunction

    function automatic grid_t model_sum(input grid_t a, input grid_t b);
        grid_t s;
        int    total;
        for (int i = 0; i < grid_size; i++) begin
            total = int'(a[i]) + int'(b[i]);
            s[i]  = elem_t'(total % 512);
        end
        return s;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_status(input logic exp_busy, input logic exp_done,
                                input logic exp_ok, input mat_dims_t exp_dims,
                                input string where);
        assert (busy === exp_busy) else
            report_error($sformatf("%s: busy is %b, expected %b", where, busy, exp_busy));
        assert (done === exp_done) else
            report_error($sformatf("%s: done is %b, expected %b", where, done, exp_done));
        assert (dims_ok === exp_ok) else
            report_error($sformatf("%s: dims_ok is %b, expected %b", where, dims_ok, exp_ok));
        assert (dims_out === exp_dims) else
            report_error($sformatf("%s: dims_out is %0dx%0d, expected %0dx%0d", where,
                                   dims_out.rows, dims_out.cols, exp_dims.rows, exp_dims.cols));
    endtask

    task automatic check_grid(input grid_t expected, input string where);
        for (int i = 0; i < grid_size; i++) begin
            assert (result[i] === expected[i]) else
                report_error($sformatf("%s: result row %0d col %0d is %0d, expected %0d",
                                       where, i / grid_dim, i % grid_dim,
                                       result[i], expected[i]));
        end
    endtask

    task automatic drive_start(input mat_dims_t da, input mat_dims_t db,
                               input grid_t a, input grid_t b);
        start  = 1'b1;
        dims_a = da;
        dims_b = db;
        data_a = a;
        data_b = b;
    endtask

    // kind selects random dims (0), equal (1), unequal (2) or equal near 511 (3)
    task automatic run_trial(input int kind);
        mat_dims_t da;
        mat_dims_t db;
        mat_dims_t exp_dims;
        grid_t     a;
        grid_t     b;
        grid_t     expected;
        bit        match;
        bit        inject;
        int        waited;
        da = random_dims();
        db = (kind == 1 || kind == 3) ? da : random_dims();
        if (kind == 2 && db == da) begin
            db.rows = dim_width'(int'(da.rows) % 5 + 1);
        end
        a      = random_grid(kind == 3);
        b      = random_grid(kind == 3);
        match  = (da == db);
        inject = (take_bits(1) != 0);
        if (match) begin
            expected = model_sum(model_order(da, a), model_order(db, b));
            exp_dims = da;
        end else begin
            expected = '0;
            exp_dims = '0;
        end

        drive_start(da, db, a, b);
        @(posedge clk);
        #1;
        start = 1'b0;

        if (match) begin
            waited = 0;
            while (done !== 1'b1) begin
                check_status(1'b1, 1'b0, 1'b1, da, "during add");
                // a second start while busy must be dropped
                if (inject && waited == 1) begin
                    drive_start(da, da, random_grid(1'b0), random_grid(1'b0));
                end else begin
                    start = 1'b0;
                end
                @(posedge clk);
                #1;
                waited++;
                assert (waited <= done_limit) else
                    report_error("done never arrived after an accepted start");
            end
            start = 1'b0;
            assert (waited == add_cycles) else
                report_error($sformatf("done after %0d edges, expected %0d", waited, add_cycles));
            check_status(1'b0, 1'b1, 1'b1, da, "at done");
        end else begin
            check_status(1'b0, 1'b1, 1'b0, '0, "mismatch");
        end
        check_grid(expected, "at done");

        // outputs hold while idle
        repeat (idle_cycles) begin
            @(posedge clk);
            #1;
            check_status(1'b0, 1'b0, match, exp_dims, "idle");
            check_grid(expected, "idle");
        end
    endtask

    initial begin
        #((num_trials * 20 + reset_cycles) * clk_period);
        $display("timeout: the run did not finish within the expected number of cycles");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int kind;
        lfsr_state = 32'h5a32;
        reset_n    = 1'b0;
        start      = 1'b0;
        dims_a     = '0;
        dims_b     = '0;
        data_a     = '0;
        data_b     = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset_n = 1'b1;

        check_status(1'b0, 1'b0, 1'b1, '0, "after reset");
        check_grid('0, "after reset");

        for (int t = 0; t < num_trials; t++) begin
            if (t < 3) begin
                kind = t + 1;
            end else if (t % 8 == 3) begin
                kind = 3;
            end else begin
                kind = (take_bits(1) != 0) ? 1 : 0;
            end
            run_trial(kind);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/add_controller.sv
`default_nettype none

module add_controller (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   start,
    input  matrix_adder_pkg::mat_dims_t            dims_a,
    input  matrix_adder_pkg::mat_dims_t            dims_b,
    output logic                                   load,
    output logic                                   row_write,
    output logic [matrix_adder_pkg::dim_width-1:0] row_index,
    output logic                                   busy,
    output logic                                   done,
    output logic                                   dims_ok,
    output matrix_adder_pkg::mat_dims_t            dims_out
);
    import matrix_adder_pkg::*;

    ctrl_state_t          state;
    logic [dim_width-1:0] row_cnt;
    logic                 accept;
    logic                 dims_match;
    logic                 last_row;

    // starts arriving mid-operation are dropped
    assign accept     = start && (state == st_idle);
    assign dims_match = (dims_a == dims_b);
    assign last_row   = (row_cnt == dim_width'(grid_dim - 1));

    assign load      = accept;
    assign busy      = (state == st_add);
    assign row_write = (state == st_add);
    assign row_index = row_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= st_idle;
            row_cnt  <= '0;
            done     <= 1'b0;
            dims_ok  <= 1'b1;
            dims_out <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        row_cnt <= '0;
                        if (dims_match) begin
                            state    <= st_add;
                            dims_ok  <= 1'b1;
                            dims_out <= dims_a;
                        end else begin
                            // mismatch finishes at once with an empty result
                            dims_ok  <= 1'b0;
                            dims_out <= '0;
                            done     <= 1'b1;
                        end
                    end
                end
                st_add: begin
                    if (last_row) begin
                        state   <= st_idle;
                        row_cnt <= '0;
                        done    <= 1'b1;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/matrix_adder.sv
`default_nettype none

module matrix_adder (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start,
    input  matrix_adder_pkg::mat_dims_t dims_a,
    input  matrix_adder_pkg::mat_dims_t dims_b,
    input  matrix_adder_pkg::grid_t     data_a,
    input  matrix_adder_pkg::grid_t     data_b,
    output logic                        busy,
    output logic                        done,
    output logic                        dims_ok,
    output matrix_adder_pkg::mat_dims_t dims_out,
    output matrix_adder_pkg::grid_t     result
);
    import matrix_adder_pkg::*;

    logic                 load;
    logic                 row_write;
    logic [dim_width-1:0] row_index;
    grid_t                grid_a;
    grid_t                grid_b;
    row_t                 sum_row;

    // operand grids captured on an accepted start
    matrix_order order_a (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (load),
        .dims    (dims_a),
        .dense   (data_a),
        .grid    (grid_a)
    );

    matrix_order order_b (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (load),
        .dims    (dims_b),
        .dense   (data_b),
        .grid    (grid_b)
    );

    row_adder u_adder (
        .grid_a    (grid_a),
        .grid_b    (grid_b),
        .row_index (row_index),
        .sum       (sum_row)
    );

    add_controller u_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .dims_a    (dims_a),
        .dims_b    (dims_b),
        .load      (load),
        .row_write (row_write),
        .row_index (row_index),
        .busy      (busy),
        .done      (done),
        .dims_ok   (dims_ok),
        .dims_out  (dims_out)
    );

    // result is wiped on the same edge the operands load
    result_store u_store (
        .clk       (clk),
        .reset_n   (reset_n),
        .clear     (load),
        .row_write (row_write),
        .row_index (row_index),
        .sum_row   (sum_row),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- verilog/matrix_adder_pkg.sv
`default_nettype none

package matrix_adder_pkg;

    // element and grid geometry
    localparam int elem_width = 9;
    localparam int grid_dim   = 5;
    localparam int grid_size  = grid_dim * grid_dim;

    // wide enough for a row count, a column count or a row index
    localparam int dim_width  = 3;

    typedef logic [elem_width-1:0] elem_t;

    // one grid row with lane 0 in the low bits
    typedef elem_t [grid_dim-1:0] row_t;

    // full grid with entry index row*grid_dim + col
    // the same layout carries the dense operand, element k at index k
    typedef elem_t [grid_size-1:0] grid_t;

    typedef struct packed {
        logic [dim_width-1:0] rows;
        logic [dim_width-1:0] cols;
    } mat_dims_t;

    typedef enum logic {
        st_idle,
        st_add
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/matrix_order.sv
`default_nettype none

module matrix_order (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        load,
    input  matrix_adder_pkg::mat_dims_t dims,
    input  matrix_adder_pkg::grid_t     dense,
    output matrix_adder_pkg::grid_t     grid
);
    import matrix_adder_pkg::*;

    grid_t placed;

    // grid slot (r, c) takes dense element r*cols + c
    // slots outside rows x cols stay zero
    always_comb begin
        int src;
        int row_lim;
        int col_lim;
        src     = 0;
        row_lim = int'(dims.rows);
        col_lim = int'(dims.cols);
        placed  = '0;
        for (int r = 0; r < grid_dim; r++) begin
            for (int c = 0; c < grid_dim; c++) begin
                src = r * col_lim + c;
                if (r < row_lim && c < col_lim && src < grid_size) begin
                    placed[r * grid_dim + c] = dense[src];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid <= '0;
        end else if (load) begin
            grid <= placed;
        end
    end

endmodule

`default_nettype wire

//--- verilog/result_store.sv
`default_nettype none

module result_store (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   clear,
    input  logic                                   row_write,
    input  logic [matrix_adder_pkg::dim_width-1:0] row_index,
    input  matrix_adder_pkg::row_t                 sum_row,
    output matrix_adder_pkg::grid_t                result
);
    import matrix_adder_pkg::*;

    logic row_in_range;

    assign row_in_range = (int'(row_index) < grid_dim);

    // clear wins over a write in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result <= '0;
        end else if (clear) begin
            result <= '0;
        end else if (row_write && row_in_range) begin
            for (int lane = 0; lane < grid_dim; lane++) begin
                result[int'(row_index) * grid_dim + lane] <= sum_row[lane];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/row_adder.sv
`default_nettype none

module row_adder (
    input  matrix_adder_pkg::grid_t                  grid_a,
    input  matrix_adder_pkg::grid_t                  grid_b,
    input  logic [matrix_adder_pkg::dim_width-1:0]   row_index,
    output matrix_adder_pkg::row_t                   sum
);
    import matrix_adder_pkg::*;

    row_t row_a;
    row_t row_b;

    // row mux where an index past the last row reads as zeros
    function automatic row_t pick_row(input grid_t g, input logic [dim_width-1:0] idx);
        row_t r;
        r = '0;
        if (int'(idx) < grid_dim) begin
            for (int lane = 0; lane < grid_dim; lane++) begin
                r[lane] = g[int'(idx) * grid_dim + lane];
            end
        end
        return r;
    endfunction

    assign row_a = pick_row(grid_a, row_index);
    assign row_b = pick_row(grid_b, row_index);

    // five lane adders drop the carry so sums wrap mod 512
    always_comb begin
        for (int lane = 0; lane < grid_dim; lane++) begin
            sum[lane] = row_a[lane] + row_b[lane];
        end
    end

endmodule

`default_nettype wire
